// ==== source/QuplsInsnPkg.sv ====
// ================================================
// Qupls instruction encoding
// Word type, opcode values and the bit positions
// of the fields that the immediate stage extracts
// ================================================

package QuplsInsnPkg;

	// One instruction word as it sits in the fetch group
	typedef logic [79:0] insnWord_t;

	// Prefix length code, selects how much payload a prefix carries
	typedef logic [1:0] pfxLen_t;

	// Seven bit major opcode in the low bits of every word
	typedef enum logic [6:0] {
		NOP   = 7'h00,
		ADDI  = 7'h04,
		CMPI  = 7'h05,
		MULI  = 7'h06,
		ANDI  = 7'h08,
		ORI   = 7'h09,
		EORI  = 7'h0A,
		CSR   = 7'h0F,
		JSR   = 7'h42,
		RTD   = 7'h43,
		LDO   = 7'h4B,
		STO   = 7'h53,
		FENCE = 7'h5F,
		FLT2  = 7'h62,
		FLT3  = 7'h63,
		PFXA  = 7'h78,
		PFXB  = 7'h79,
		PFXC  = 7'h7A
	} opcode_e;

	// ================================================
	// Field positions
	// ================================================
	localparam int opcodeHi = 6;
	localparam int pfxLenLo = 7;
	localparam int pfxLenHi = 8;
	// Prefix payload, full and short forms all start at bit 9
	localparam int pfxPayloadLo = 9;
	localparam int pfxPayloadHi = 72;
	localparam int pfxShortHi = 31;
	localparam int pfxMidHi = 47;
	localparam int pfxSingleHi = 40;
	// Immediate fields of the leading instruction itself
	localparam int immLo = 19;
	localparam int immShortHi = 31;
	localparam int csrHi = 29;
	localparam int immLongHi = 39;
	localparam int fenceLo = 8;
	localparam int fenceHi = 23;

	// Filler for window positions past the end of a group
	localparam insnWord_t nopWord = insnWord_t'(NOP);

	function automatic opcode_e opcodeOf(insnWord_t w);
		return opcode_e'(w[opcodeHi:0]);
	endfunction

	function automatic pfxLen_t pfxLenOf(insnWord_t w);
		return w[pfxLenHi:pfxLenLo];
	endfunction

	function automatic logic isPrefix(opcode_e op);
		return (op == PFXA) || (op == PFXB) || (op == PFXC);
	endfunction

endpackage

// ==== source/QuplsImmPkg.sv ====
// ================================================
// Qupls immediate values
// Value types used by the immediate decoders and
// the depth of the per-lane instruction window
// ================================================

package QuplsImmPkg;

	// A fully decoded immediate as handed to later stages
	typedef logic [63:0] imm64_t;

	// IEEE single as carried in a short float prefix
	typedef logic [31:0] fpSingle_t;

	// IEEE double, the widened form of a single
	typedef logic [63:0] fpDouble_t;

	// A lane sees its own word plus up to three prefixes after it
	localparam int windowDepth = 4;

endpackage

// ==== source/QuplsSlotIf.sv ====
// ================================================
// Per-lane slot interface
// Carries one lane's instruction window and lead
// flag to a decoder, and its immediates onward
// ================================================

`timescale 1ns/1ps

interface QuplsSlotIf;

	// Word 0 is the lane's own word, words 1 to 3 the candidates for prefixes
	QuplsInsnPkg::insnWord_t [QuplsImmPkg::windowDepth-1:0] window;
	// Set when word 0 starts an instruction in a valid group
	logic lead;
	// Registered group valid, carried so the collector also sees all-prefix groups
	logic strobe;
	QuplsImmPkg::imm64_t immA;
	QuplsImmPkg::imm64_t immB;
	QuplsImmPkg::imm64_t immC;

	modport feed (output window, output lead, output strobe);
	modport decode (input window, output immA, output immB, output immC);
	modport drain (input lead, input strobe, input immA, input immB, input immC);

endinterface

// ==== source/QuplsSlotSplitter.sv ====
// ================================================
// Fetch group splitter
// Registers a fetch group on its strobe and gives
// every lane a window of four words and a lead flag
// ================================================

`timescale 1ns/1ps

module QuplsSlotSplitter #(
	parameter int LANES = 8
) (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input QuplsInsnPkg::insnWord_t [LANES-1:0] fetchGroup,
	QuplsSlotIf.feed slots [LANES]
);

	// Registered group, only loaded when a strobe arrives
	QuplsInsnPkg::insnWord_t [LANES-1:0] groupQ;
	// High for the one cycle after a sampled strobe
	logic validQ;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= fetchValid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetchValid) begin
			groupQ <= fetchGroup;
		end
	end

	// ================================================
	// Lane windows
	// ================================================
	for (genvar i = 0; i < LANES; i++) begin : gLane
		for (genvar k = 0; k < QuplsImmPkg::windowDepth; k++) begin : gWord
			if (i + k < LANES) begin : gIn
				assign slots[i].window[k] = groupQ[i + k];
			end else begin : gPad
				// Prefixes never reach into the next group, so pad with NOP
				assign slots[i].window[k] = QuplsInsnPkg::nopWord;
			end
		end

		// A prefix word never starts an instruction of its own
		assign slots[i].lead = validQ &&
			!QuplsInsnPkg::isPrefix(QuplsInsnPkg::opcodeOf(groupQ[i]));
		assign slots[i].strobe = validQ;
	end

	// The fetch unit must present a fully defined group with its strobe
	aGroupKnown: assert property (
		@(posedge clk) disable iff (!arstN)
		fetchValid |-> !$isunknown(fetchGroup)
	);

endmodule

// ==== source/fpCvt32To64.sv ====
// ================================================
// Single to double conversion
// Exact widening of an IEEE single, subnormal
// inputs are normalized into the wider exponent
// ================================================

`timescale 1ns/1ps

module fpCvt32To64 (
	input QuplsImmPkg::fpSingle_t single,
	output QuplsImmPkg::fpDouble_t double
);

	logic sign;
	logic [7:0] expS;
	logic [22:0] manS;
	// Leading zeros of the single mantissa, only meaningful for subnormals
	logic [4:0] lz;
	logic [22:0] manNorm;
	logic [10:0] expD;
	logic [51:0] manD;

	assign sign = single[31];
	assign expS = single[30:23];
	assign manS = single[22:0];

	// Highest set bit wins because later iterations overwrite earlier ones
	always_comb begin
		lz = 5'd0;
		for (int b = 0; b < 23; b++) begin
			if (manS[b]) begin
				lz = 5'(22 - b);
			end
		end
	end

	// Shift the leading one out of the field, it becomes the hidden bit
	assign manNorm = manS << (lz + 5'd1);

	always_comb begin
		if (expS == 8'd0 && manS == 23'd0) begin
			// Signed zero stays signed zero
			expD = 11'd0;
			manD = 52'd0;
		end else if (expS == 8'hFF) begin
			// Infinity and NaN, the payload moves to the top mantissa bits
			expD = 11'h7FF;
			manD = {manS, 29'd0};
		end else if (expS == 8'd0) begin
			// Subnormal 0.m x 2^-126 becomes 1.f x 2^(-127-lz)
			expD = 11'd896 - 11'(lz);
			manD = {manNorm, 29'd0};
		end else begin
			// Rebias from 127 to 1023
			expD = 11'(expS) + 11'd896;
			manD = {manS, 29'd0};
		end
	end

	assign double = {sign, expD, manD};

endmodule

// ==== source/QuplsImmDecoder.sv ====
// ================================================
// Immediate decoder for one lane
// Builds the base immediate from the leading word
// and applies up to three prefixes in A, B, C order
// ================================================

`timescale 1ns/1ps

module QuplsImmDecoder (
	QuplsSlotIf.decode slot
);

	localparam int immShortBits = QuplsInsnPkg::immShortHi - QuplsInsnPkg::immLo + 1;

	QuplsInsnPkg::opcode_e ops [QuplsImmPkg::windowDepth];
	QuplsInsnPkg::opcode_e leadOp;
	QuplsInsnPkg::insnWord_t w0;
	logic isFlt;
	logic hasA;
	logic hasB;
	logic hasC;
	// Window positions that the B and C prefixes would occupy
	logic [1:0] posB;
	logic [1:0] posC;
	QuplsImmPkg::fpDouble_t cvtA;
	QuplsImmPkg::fpDouble_t cvtB;
	QuplsImmPkg::fpDouble_t cvtC;
	QuplsImmPkg::imm64_t baseB;

	// Value carried by one prefix word, float leads change the length meaning
	function automatic QuplsImmPkg::imm64_t pfxValue(
		QuplsInsnPkg::insnWord_t w,
		logic flt,
		QuplsImmPkg::fpDouble_t cvt
	);
		QuplsImmPkg::imm64_t v;
		if (flt) begin
			case (QuplsInsnPkg::pfxLenOf(w))
				2'd1: v = cvt;
				2'd2: v = w[QuplsInsnPkg::pfxPayloadHi:QuplsInsnPkg::pfxPayloadLo];
				default: v = '0;
			endcase
		end else begin
			case (QuplsInsnPkg::pfxLenOf(w))
				2'd0: v = $signed(w[QuplsInsnPkg::pfxShortHi:QuplsInsnPkg::pfxPayloadLo]);
				2'd1: v = $signed(w[QuplsInsnPkg::pfxMidHi:QuplsInsnPkg::pfxPayloadLo]);
				default: v = w[QuplsInsnPkg::pfxPayloadHi:QuplsInsnPkg::pfxPayloadLo];
			endcase
		end
		return v;
	endfunction

	for (genvar k = 0; k < QuplsImmPkg::windowDepth; k++) begin : gOp
		assign ops[k] = QuplsInsnPkg::opcodeOf(slot.window[k]);
	end

	assign w0 = slot.window[0];
	assign leadOp = ops[0];
	assign isFlt = (leadOp == QuplsInsnPkg::FLT2) || (leadOp == QuplsInsnPkg::FLT3);

	// ================================================
	// Prefix chain cursor
	// ================================================
	// Each prefix that matches moves the cursor one word on
	assign hasA = ops[1] == QuplsInsnPkg::PFXA;
	assign posB = hasA ? 2'd2 : 2'd1;
	assign hasB = ops[posB] == QuplsInsnPkg::PFXB;
	assign posC = posB + 2'(hasB);
	assign hasC = ops[posC] == QuplsInsnPkg::PFXC;

	// One converter per immediate, fed from wherever that prefix would sit
	fpCvt32To64 uCvtA (
		.single(slot.window[1][QuplsInsnPkg::pfxSingleHi:QuplsInsnPkg::pfxPayloadLo]),
		.double(cvtA)
	);
	fpCvt32To64 uCvtB (
		.single(slot.window[posB][QuplsInsnPkg::pfxSingleHi:QuplsInsnPkg::pfxPayloadLo]),
		.double(cvtB)
	);
	fpCvt32To64 uCvtC (
		.single(slot.window[posC][QuplsInsnPkg::pfxSingleHi:QuplsInsnPkg::pfxPayloadLo]),
		.double(cvtC)
	);

	// ================================================
	// Base immediate from the leading word
	// ================================================
	always_comb begin
		case (leadOp)
			QuplsInsnPkg::ADDI, QuplsInsnPkg::CMPI, QuplsInsnPkg::MULI:
				baseB = $signed(w0[QuplsInsnPkg::immShortHi:QuplsInsnPkg::immLo]);
			// AND masks keep their upper bits, so extend with ones
			QuplsInsnPkg::ANDI:
				baseB = {{(64 - immShortBits){1'b1}},
					w0[QuplsInsnPkg::immShortHi:QuplsInsnPkg::immLo]};
			QuplsInsnPkg::ORI, QuplsInsnPkg::EORI:
				baseB = w0[QuplsInsnPkg::immShortHi:QuplsInsnPkg::immLo];
			// CSR number, unsigned
			QuplsInsnPkg::CSR:
				baseB = w0[QuplsInsnPkg::csrHi:QuplsInsnPkg::immLo];
			QuplsInsnPkg::JSR, QuplsInsnPkg::RTD, QuplsInsnPkg::LDO, QuplsInsnPkg::STO:
				baseB = $signed(w0[QuplsInsnPkg::immLongHi:QuplsInsnPkg::immLo]);
			QuplsInsnPkg::FENCE:
				baseB = w0[QuplsInsnPkg::fenceHi:QuplsInsnPkg::fenceLo];
			default:
				baseB = '0;
		endcase
	end

	// A prefix overrides whatever the leading word supplied
	always_comb begin
		slot.immA = '0;
		slot.immB = baseB;
		slot.immC = '0;
		if (hasA) begin
			slot.immA = pfxValue(slot.window[1], isFlt, cvtA);
		end
		if (hasB) begin
			slot.immB = pfxValue(slot.window[posB], isFlt, cvtB);
		end
		if (hasC) begin
			slot.immC = pfxValue(slot.window[posC], isFlt, cvtC);
		end
	end

endmodule

// ==== source/QuplsImmCollector.sv ====
// ================================================
// Immediate collector
// Registers every lane's immediates, the lead mask
// and a one cycle valid pulse per fetch group
// ================================================

`timescale 1ns/1ps

module QuplsImmCollector #(
	parameter int LANES = 8
) (
	input logic clk,
	input logic arstN,
	QuplsSlotIf.drain slots [LANES],
	output logic immValid,
	output logic [LANES-1:0] leadMask,
	output QuplsImmPkg::imm64_t [LANES-1:0] immA,
	output QuplsImmPkg::imm64_t [LANES-1:0] immB,
	output QuplsImmPkg::imm64_t [LANES-1:0] immC
);

	logic [LANES-1:0] leads;
	logic [LANES-1:0] strobes;
	logic groupValid;
	QuplsImmPkg::imm64_t [LANES-1:0] laneA;
	QuplsImmPkg::imm64_t [LANES-1:0] laneB;
	QuplsImmPkg::imm64_t [LANES-1:0] laneC;

	// Lanes holding a prefix report zero rather than half a chain
	for (genvar i = 0; i < LANES; i++) begin : gLane
		assign leads[i] = slots[i].lead;
		assign strobes[i] = slots[i].strobe;
		assign laneA[i] = slots[i].lead ? slots[i].immA : '0;
		assign laneB[i] = slots[i].lead ? slots[i].immB : '0;
		assign laneC[i] = slots[i].lead ? slots[i].immC : '0;
	end

	// The strobe bit covers groups made only of prefixes
	assign groupValid = (|leads) | (|strobes);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			immValid <= 1'b0;
			leadMask <= '0;
			immA <= '0;
			immB <= '0;
			immC <= '0;
		end else begin
			immValid <= groupValid;
			// Leads are already zero between groups
			leadMask <= leads;
			if (groupValid) begin
				immA <= laneA;
				immB <= laneB;
				immC <= laneC;
			end
		end
	end

	// Lead flags from the splitter only ever appear with a valid group
	aMaskIdle: assert property (
		@(posedge clk) disable iff (!arstN)
		!immValid |-> leadMask == '0
	);

endmodule

// ==== source/QuplsImmDecodeTop.sv ====
// ================================================
// Immediate extraction stage
// Splitter, one decoder per lane and a collector,
// two cycles from fetch strobe to immediates
// ================================================

`timescale 1ns/1ps

module QuplsImmDecodeTop #(
	parameter int LANES = 8
) (
	input logic clk,
	input logic arstN,
	input logic fetchValid,
	input QuplsInsnPkg::insnWord_t [LANES-1:0] fetchGroup,
	output logic immValid,
	output logic [LANES-1:0] leadMask,
	output QuplsImmPkg::imm64_t [LANES-1:0] immA,
	output QuplsImmPkg::imm64_t [LANES-1:0] immB,
	output QuplsImmPkg::imm64_t [LANES-1:0] immC
);

	// One slot per word position of the group
	QuplsSlotIf slots [LANES] ();

	QuplsSlotSplitter #(.LANES(LANES)) uSplitter (
		.clk(clk),
		.arstN(arstN),
		.fetchValid(fetchValid),
		.fetchGroup(fetchGroup),
		.slots(slots)
	);

	// Decoders are purely combinational between the two register stages
	for (genvar i = 0; i < LANES; i++) begin : gDec
		QuplsImmDecoder uDecoder (
			.slot(slots[i])
		);
	end

	QuplsImmCollector #(.LANES(LANES)) uCollector (
		.clk(clk),
		.arstN(arstN),
		.slots(slots),
		.immValid(immValid),
		.leadMask(leadMask),
		.immA(immA),
		.immB(immB),
		.immC(immC)
	);

endmodule

// ==== bench/QuplsImmDecodeTb.sv ====
// ================================================
// Testbench for the immediate extraction stage
// Directed and LFSR driven fetch groups, checked
// against a reference model two cycles later
// ================================================

`timescale 1ns/1ps

module QuplsImmDecodeTb;

	localparam int LANES = 8;
	localparam int resetCycles = 5;
	localparam int idleCycles = 10;
	localparam int baseGroups = 14;
	localparam int chainGroups = 8;
	localparam int randGroups = 200;
	localparam int gapGroups = 100;
	localparam int maxGap = 3;
	// Every test ends with a drain of at most four cycles
	localparam int stimCycles = resetCycles + 2 * idleCycles + baseGroups + chainGroups
		+ randGroups + gapGroups * (maxGap + 1) + 6 * 4;
	localparam int cycleLimit = stimCycles + 100;

	typedef logic [LANES-1:0][79:0] group_t;
	typedef logic [LANES-1:0][63:0] laneImm_t;

	// Each lead opcode of the base test, NOP and FLT2 stand for the zero class
	localparam logic [6:0] baseOps [baseGroups] = '{
		QuplsInsnPkg::ADDI, QuplsInsnPkg::CMPI, QuplsInsnPkg::MULI, QuplsInsnPkg::ANDI,
		QuplsInsnPkg::ORI, QuplsInsnPkg::EORI, QuplsInsnPkg::CSR, QuplsInsnPkg::JSR,
		QuplsInsnPkg::RTD, QuplsInsnPkg::LDO, QuplsInsnPkg::STO, QuplsInsnPkg::FENCE,
		QuplsInsnPkg::NOP, QuplsInsnPkg::FLT2
	};
	localparam logic [6:0] pfxOps [3] = '{
		QuplsInsnPkg::PFXA, QuplsInsnPkg::PFXB, QuplsInsnPkg::PFXC
	};
	// Normals, signed zeros, infinities, NaNs and subnormals
	localparam logic [31:0] singles [10] = '{
		32'h3FC00000, 32'h40490FDB, 32'h00000000, 32'h80000000, 32'h7F800000,
		32'hFF800000, 32'h7FC00001, 32'h7FA00000, 32'h00000001, 32'h807FFFFF
	};

	logic clk;
	logic arstN;
	logic fetchValid;
	group_t fetchGroup;
	logic immValid;
	logic [LANES-1:0] leadMask;
	laneImm_t immA;
	laneImm_t immB;
	laneImm_t immC;

	logic [31:0] lfsrState;
	int cycle = 0;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	// Expected results in strobe order, with the cycle their pulse is due
	logic [LANES-1:0] expLead [$];
	laneImm_t expA [$];
	laneImm_t expB [$];
	laneImm_t expC [$];
	int expDue [$];

	QuplsImmDecodeTop #(.LANES(LANES)) i_QuplsImmDecodeTop (.*);

	always #4 clk = ~clk;

	// ================================================
	// Random stimulus
	// ================================================
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [63:0] randBits(input int n);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[62:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic logic [79:0] randomWord(input logic [6:0] op);
		logic [63:0] lo;
		logic [8:0] hi;
		lo = randBits(64);
		hi = 9'(randBits(9));
		return {hi, lo, op};
	endfunction

	function automatic logic [79:0] prefixWord(input logic [6:0] op, input logic [1:0] len);
		logic [79:0] w;
		w = randomWord(op);
		w[8:7] = len;
		return w;
	endfunction

	// Prefixes take half of the table so that chains form often
	function automatic logic [6:0] randomOpcode();
		case (4'(randBits(4)))
			4'd0, 4'd1, 4'd2: return QuplsInsnPkg::PFXA;
			4'd3, 4'd4, 4'd5: return QuplsInsnPkg::PFXB;
			4'd6, 4'd7: return QuplsInsnPkg::PFXC;
			4'd8: return QuplsInsnPkg::ADDI;
			4'd9: return QuplsInsnPkg::ANDI;
			4'd10: return QuplsInsnPkg::CSR;
			4'd11: return QuplsInsnPkg::LDO;
			4'd12: return QuplsInsnPkg::FENCE;
			4'd13: return QuplsInsnPkg::FLT2;
			4'd14: return QuplsInsnPkg::FLT3;
			default: return QuplsInsnPkg::ORI;
		endcase
	endfunction

	function automatic group_t randomGroup();
		group_t g;
		for (int i = 0; i < LANES; i++) begin
			g[i] = randomWord(randomOpcode());
		end
		return g;
	endfunction

	// ================================================
	// Reference model
	// ================================================
	function automatic logic [63:0] signExtend(input logic [63:0] v, input int bits);
		logic [63:0] upper;
		upper = ~64'd0 << bits;
		return v[bits - 1] ? (v | upper) : (v & ~upper);
	endfunction

	// Normalizes subnormals by shifting until the hidden bit appears
	function automatic logic [63:0] widenSingle(input logic [31:0] s);
		logic [23:0] frac;
		int ex;
		if (s[30:23] == 8'hFF) begin
			return {s[31], 11'h7FF, s[22:0], 29'd0};
		end
		if (s[30:0] == 31'd0) begin
			return {s[31], 63'd0};
		end
		if (s[30:23] != 8'd0) begin
			return {s[31], 11'(int'(s[30:23]) - 127 + 1023), s[22:0], 29'd0};
		end
		ex = -126;
		frac = {1'b0, s[22:0]};
		while (!frac[23]) begin
			frac = frac << 1;
			ex--;
		end
		return {s[31], 11'(ex + 1023), frac[22:0], 29'd0};
	endfunction

	// Top bit of the selector is the float lead, low bits the length code
	function automatic logic [63:0] prefixValue(input logic [79:0] w, input logic flt);
		case ({flt, w[8:7]})
			3'b000: return signExtend(64'(w[31:9]), 23);
			3'b001: return signExtend(64'(w[47:9]), 39);
			3'b010, 3'b011, 3'b110: return w[72:9];
			3'b101: return widenSingle(w[40:9]);
			default: return '0;
		endcase
	endfunction

	function automatic logic [63:0] baseImm(input logic [79:0] w);
		case (w[6:0])
			QuplsInsnPkg::ADDI, QuplsInsnPkg::CMPI, QuplsInsnPkg::MULI:
				return signExtend(64'(w[31:19]), 13);
			QuplsInsnPkg::ANDI:
				return {{51{1'b1}}, w[31:19]};
			QuplsInsnPkg::ORI, QuplsInsnPkg::EORI:
				return 64'(w[31:19]);
			QuplsInsnPkg::CSR:
				return 64'(w[29:19]);
			QuplsInsnPkg::JSR, QuplsInsnPkg::RTD, QuplsInsnPkg::LDO, QuplsInsnPkg::STO:
				return signExtend(64'(w[39:19]), 21);
			QuplsInsnPkg::FENCE:
				return 64'(w[23:8]);
			default:
				return '0;
		endcase
	endfunction

	function automatic void refModel(input group_t g, output logic [LANES-1:0] lead,
		output laneImm_t a, output laneImm_t b, output laneImm_t c);
		logic [79:0] win [4];
		logic [6:0] op;
		logic flt;
		int cur;
		for (int i = 0; i < LANES; i++) begin
			op = g[i][6:0];
			lead[i] = !(op == QuplsInsnPkg::PFXA || op == QuplsInsnPkg::PFXB ||
				op == QuplsInsnPkg::PFXC);
			a[i] = '0;
			b[i] = '0;
			c[i] = '0;
			if (lead[i]) begin
				// Words past the group end read as NOP
				for (int k = 0; k < 4; k++) begin
					win[k] = 80'(QuplsInsnPkg::NOP);
					if (i + k < LANES) begin
						win[k] = g[(i + k) % LANES];
					end
				end
				flt = (op == QuplsInsnPkg::FLT2) || (op == QuplsInsnPkg::FLT3);
				b[i] = baseImm(g[i]);
				cur = 1;
				if (win[cur][6:0] == QuplsInsnPkg::PFXA) begin
					a[i] = prefixValue(win[cur], flt);
					cur++;
				end
				if (win[cur][6:0] == QuplsInsnPkg::PFXB) begin
					b[i] = prefixValue(win[cur], flt);
					cur++;
				end
				if (win[cur][6:0] == QuplsInsnPkg::PFXC) begin
					c[i] = prefixValue(win[cur], flt);
				end
			end
		end
	endfunction

	// ================================================
	// Driving and checking
	// ================================================
	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected 0x%016h actual 0x%016h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic sendGroup(input group_t g);
		logic [LANES-1:0] lead;
		laneImm_t a;
		laneImm_t b;
		laneImm_t c;
		@(posedge clk);
		refModel(g, lead, a, b, c);
		expLead.push_back(lead);
		expA.push_back(a);
		expB.push_back(b);
		expC.push_back(c);
		// The counter still reads the previous edge here, so the pulse is seen three on
		expDue.push_back(cycle + 3);
		fetchValid <= 1'b1;
		fetchGroup <= g;
	endtask

	task automatic idleFor(input int n);
		repeat (n) begin
			@(posedge clk);
			fetchValid <= 1'b0;
		end
	endtask

	task automatic drainQueue();
		idleFor(1);
		while (expDue.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic finishTest(input string name, input int errsBefore);
		if (errorCount == errsBefore) begin
			testsPassed++;
			$display("PASS %s", name);
		end else begin
			testsFailed++;
			$display("FAIL %s with %0d mismatches", name, errorCount - errsBefore);
		end
	endtask

	// Sampled on the falling edge, halfway between register updates
	always @(negedge clk) begin
		laneImm_t a;
		laneImm_t b;
		laneImm_t c;
		if (arstN && immValid) begin
			if (expDue.size() == 0) begin
				$display("Unexpected immValid pulse at cycle %0d with no group in flight", cycle);
				errorCount++;
			end else begin
				checkValue("immValid cycle", 64'(expDue.pop_front()), 64'(cycle));
				checkValue("leadMask", 64'(expLead.pop_front()), 64'(leadMask));
				a = expA.pop_front();
				b = expB.pop_front();
				c = expC.pop_front();
				for (int i = 0; i < LANES; i++) begin
					checkValue($sformatf("immA[%0d]", i), a[i], immA[i]);
					checkValue($sformatf("immB[%0d]", i), b[i], immB[i]);
					checkValue($sformatf("immC[%0d]", i), c[i], immC[i]);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		group_t g;
		int errs;
		clk = 1'b0;
		arstN = 1'b0;
		fetchValid = 1'b0;
		fetchGroup = '0;
		lfsrState = 32'hffa94a2d;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;

		// Outputs stay at their reset values while no group arrives
		errs = errorCount;
		repeat (idleCycles) begin
			@(negedge clk);
			checkValue("immValid", 64'd0, 64'(immValid));
			checkValue("leadMask", 64'd0, 64'(leadMask));
			for (int i = 0; i < LANES; i++) begin
				checkValue($sformatf("immA[%0d]", i), 64'd0, immA[i]);
				checkValue($sformatf("immB[%0d]", i), 64'd0, immB[i]);
				checkValue($sformatf("immC[%0d]", i), 64'd0, immC[i]);
			end
		end
		finishTest("reset idle", errs);

		errs = errorCount;
		for (int t = 0; t < baseGroups; t++) begin
			for (int i = 0; i < LANES; i++) begin
				g[i] = randomWord(baseOps[t]);
			end
			sendGroup(g);
		end
		drainQueue();
		finishTest("base immediates", errs);

		// Full A B C chain, then B before A, then a lead at the group end
		errs = errorCount;
		for (int l = 0; l < 4; l++) begin
			g[0] = randomWord(QuplsInsnPkg::ADDI);
			for (int j = 1; j < 4; j++) begin
				g[j] = prefixWord(pfxOps[j - 1], 2'(l));
			end
			g[4] = randomWord(QuplsInsnPkg::LDO);
			g[5] = prefixWord(QuplsInsnPkg::PFXB, 2'(l));
			g[6] = prefixWord(QuplsInsnPkg::PFXA, 2'(l));
			g[7] = randomWord(QuplsInsnPkg::ORI);
			sendGroup(g);
		end
		drainQueue();
		finishTest("integer prefix chains", errs);

		errs = errorCount;
		for (int n = 0; n < 4; n++) begin
			g[0] = randomWord(QuplsInsnPkg::FLT2);
			for (int j = 1; j < 4; j++) begin
				g[j] = prefixWord(pfxOps[j - 1], 2'd1);
				g[j][40:9] = singles[(3 * n + j - 1) % 10];
			end
			g[4] = randomWord(QuplsInsnPkg::FLT3);
			g[5] = prefixWord(QuplsInsnPkg::PFXA, 2'd0);
			g[6] = prefixWord(QuplsInsnPkg::PFXB, 2'd3);
			g[7] = prefixWord(QuplsInsnPkg::PFXC, 2'd2);
			sendGroup(g);
		end
		drainQueue();
		finishTest("float prefixes", errs);

		errs = errorCount;
		for (int n = 0; n < randGroups; n++) begin
			sendGroup(randomGroup());
		end
		drainQueue();
		finishTest("back to back random groups", errs);

		// The last pulse is due two cycles after its strobe, well inside the idle tail
		errs = errorCount;
		for (int n = 0; n < gapGroups; n++) begin
			sendGroup(randomGroup());
			idleFor(int'(randBits(2)));
		end
		idleFor(idleCycles);
		if (expDue.size() != 0) begin
			$display("Expected queue still holds %0d results at the end", expDue.size());
			errorCount++;
		end
		finishTest("random gaps", errs);

		$display("Tests: %0d passed, %0d failed", testsPassed, testsFailed);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== QuplsImmDecodeTop.f ====
source/QuplsInsnPkg.sv
source/QuplsImmPkg.sv
source/QuplsSlotIf.sv
source/QuplsSlotSplitter.sv
source/fpCvt32To64.sv
source/QuplsImmDecoder.sv
source/QuplsImmCollector.sv
source/QuplsImmDecodeTop.sv
bench/QuplsImmDecodeTb.sv

// ==== Makefile ====
# Verilator build and run for the immediate extraction stage

TOP ?= QuplsImmDecodeTb
FILELIST ?= QuplsImmDecodeTop.f
VERILATOR ?= verilator
VFLAGS ?= --timing --assert -Wno-fatal
OBJDIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# The run fails unless the pass message shows up in the output
run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

lint:
	$(VERILATOR) $(VFLAGS) --lint-only --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
